// File: enet_reg_pkg.sv
package enet_reg_pkg;

    localparam int ADDR_W  = 12;
    localparam int DATA_W  = 32;
    // {data, addr, rd}
    localparam int MSG_W   = DATA_W + ADDR_W + 1;
    // {data, addr}
    localparam int REPLY_W = DATA_W + ADDR_W;

    localparam logic [ADDR_W-1:0] ADDR_EIR  = 12'h004;
    localparam logic [ADDR_W-1:0] ADDR_EIMR = 12'h008;
    localparam logic [ADDR_W-1:0] ADDR_RDAR = 12'h010;
    localparam logic [ADDR_W-1:0] ADDR_TDAR = 12'h014;
    localparam logic [ADDR_W-1:0] ADDR_ECR  = 12'h024;
    localparam logic [ADDR_W-1:0] ADDR_RCR  = 12'h084;
    localparam logic [ADDR_W-1:0] ADDR_TCR  = 12'h0C4;
    localparam logic [ADDR_W-1:0] ADDR_PALR = 12'h0E4;
    localparam logic [ADDR_W-1:0] ADDR_PAUR = 12'h0E8;
    localparam logic [ADDR_W-1:0] ADDR_RAEM = 12'h194;
    localparam logic [ADDR_W-1:0] ADDR_RAFL = 12'h198;
    localparam logic [ADDR_W-1:0] ADDR_TIPG = 12'h1A0;
    localparam logic [ADDR_W-1:0] ADDR_TAEM = 12'h1A4;
    localparam logic [ADDR_W-1:0] ADDR_TAFL = 12'h1A8;

    // stored field widths
    localparam int PAUR_HI_W = 16;
    localparam int TIPG_W    = 5;
    localparam int THR_W     = 8;

    localparam logic [15:0] PAUR_TYPE = 16'h8808;
    localparam int TIPG_RST       = 12;
    localparam int TAFL_MAX       = 240;
    localparam int RAFL_MAX       = 251;
    localparam int AEM_MIN        = 4;
    localparam int DAR_ACTIVE_BIT = 24;

    // eir bits as seen in host write data
    localparam int EIR_BABR  = 30;
    localparam int EIR_BABT  = 29;
    localparam int EIR_GRA   = 28;
    localparam int EIR_TXF   = 27;
    localparam int EIR_RXF   = 25;
    localparam int EIR_EBERR = 22;
    localparam int EIR_LC    = 21;
    localparam int EIR_RL    = 20;
    localparam int EIR_UN    = 19;
    localparam int EIR_PLR   = 18;

    // same events inside a reply word
    localparam int EV_BABR  = 42;
    localparam int EV_BABT  = 41;
    localparam int EV_GRA   = 40;
    localparam int EV_TXF   = 39;
    localparam int EV_RXF   = 37;
    localparam int EV_EBERR = 34;
    localparam int EV_LC    = 33;
    localparam int EV_RL    = 32;
    localparam int EV_UN    = 31;
    localparam int EV_PLR   = 30;

    typedef enum logic [3:0] {
        REG_NONE, REG_EIR, REG_EIMR, REG_ECR, REG_TCR, REG_RCR, REG_TDAR, REG_RDAR,
        REG_PALR, REG_PAUR, REG_TIPG, REG_TAFL, REG_TAEM, REG_RAFL, REG_RAEM
    } reg_id_e;

    typedef enum logic [1:0] {ROUTE_LOCAL, ROUTE_TX, ROUTE_RX, ROUTE_BOTH} route_e;

    typedef enum logic {CHAN_TX, CHAN_RX} chan_e;

endpackage

// File: enet_reg_decode.sv
`timescale 1ns/1ps

module enet_reg_decode import enet_reg_pkg::*; (
    input  logic              reg_wen,
    input  logic              reg_ren,
    input  logic [ADDR_W-1:0] reg_addr,
    input  logic              tx_out_full,
    input  logic              rx_out_full,
    output logic              write_success,
    output logic              tx_send,
    output logic              rx_send,
    output logic              tx_rd_req,
    output logic              rx_rd_req,
    output logic              cfg_we,
    output reg_id_e           cfg_id,
    output logic              eir_clr_we
);

    reg_id_e reg_id;
    route_e  route;
    logic    route_ok;

    always_comb begin
        case (reg_addr)
            ADDR_EIR:  reg_id = REG_EIR;
            ADDR_EIMR: reg_id = REG_EIMR;
            ADDR_ECR:  reg_id = REG_ECR;
            ADDR_TCR:  reg_id = REG_TCR;
            ADDR_RCR:  reg_id = REG_RCR;
            ADDR_TDAR: reg_id = REG_TDAR;
            ADDR_RDAR: reg_id = REG_RDAR;
            ADDR_PALR: reg_id = REG_PALR;
            ADDR_PAUR: reg_id = REG_PAUR;
            ADDR_TIPG: reg_id = REG_TIPG;
            ADDR_TAFL: reg_id = REG_TAFL;
            ADDR_TAEM: reg_id = REG_TAEM;
            ADDR_RAFL: reg_id = REG_RAFL;
            ADDR_RAEM: reg_id = REG_RAEM;
            default:   reg_id = REG_NONE;
        endcase
    end

    // owning side of each register
    always_comb begin
        case (reg_id)
            REG_ECR, REG_PALR, REG_PAUR:                     route = ROUTE_BOTH;
            REG_TCR, REG_TDAR, REG_TIPG, REG_TAFL, REG_TAEM: route = ROUTE_TX;
            REG_RCR, REG_RDAR, REG_RAFL, REG_RAEM:           route = ROUTE_RX;
            default:                                         route = ROUTE_LOCAL;
        endcase
    end

    // every fifo on the route must have room
    always_comb begin
        case (route)
            ROUTE_TX:   route_ok = !tx_out_full;
            ROUTE_RX:   route_ok = !rx_out_full;
            ROUTE_BOTH: route_ok = !tx_out_full && !rx_out_full;
            default:    route_ok = 1'b1;
        endcase
    end

    assign write_success = reg_wen && (reg_id != REG_NONE) && route_ok;

    assign tx_send = write_success && (route == ROUTE_TX || route == ROUTE_BOTH);
    assign rx_send = write_success && (route == ROUTE_RX || route == ROUTE_BOTH);

    assign cfg_id = reg_id;
    assign cfg_we = write_success && (reg_id inside {REG_EIMR, REG_PALR, REG_PAUR, REG_TIPG,
                                                     REG_TAFL, REG_TAEM, REG_RAFL, REG_RAEM});
    assign eir_clr_we = write_success && (reg_id == REG_EIR);

    // remote reads, split by owning side
    assign tx_rd_req = reg_ren && (reg_id == REG_TCR || reg_id == REG_TDAR);
    assign rx_rd_req = reg_ren && (reg_id == REG_RCR || reg_id == REG_RDAR);

endmodule

// File: enet_msg_sender.sv
`timescale 1ns/1ps

module enet_msg_sender import enet_reg_pkg::*; #(
    parameter chan_e CHAN = CHAN_TX
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              send,
    input  logic              rd_req,
    input  logic              read_done,
    input  logic              out_full,
    input  logic [ADDR_W-1:0] reg_addr,
    input  logic [DATA_W-1:0] reg_wdata,
    output logic              out_wen,
    output logic [MSG_W-1:0]  out_data
);

    typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_WAIT} state_e;

    state_e           state;
    logic [MSG_W-1:0] msg;
    logic             own_rd;

    // read flag only for this side's readable registers
    assign own_rd = (CHAN == CHAN_TX) ? (reg_addr == ADDR_TCR || reg_addr == ADDR_TDAR)
                                      : (reg_addr == ADDR_RCR || reg_addr == ADDR_RDAR);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            out_wen <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (send) begin
                        out_wen <= 1'b1;
                    end else if (rd_req && own_rd) begin
                        out_wen <= 1'b1;
                        state   <= ST_REQ;
                    end else begin
                        out_wen <= 1'b0;
                    end
                end
                ST_REQ: begin
                    // keep offering the request until the fifo takes it
                    if (read_done) begin
                        out_wen <= 1'b0;
                        state   <= ST_IDLE;
                    end else if (!out_full) begin
                        out_wen <= 1'b0;
                        state   <= ST_WAIT;
                    end
                end
                default: begin
                    out_wen <= 1'b0;
                    if (read_done) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            msg <= '0;
        end else if (state == ST_IDLE && (send || (rd_req && own_rd))) begin
            msg <= {reg_wdata, reg_addr, !send};
        end
    end

    assign out_data = msg;

endmodule

// File: enet_cfg_regs.sv
`timescale 1ns/1ps

module enet_cfg_regs import enet_reg_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cfg_we,
    input  reg_id_e           cfg_id,
    input  logic [DATA_W-1:0] reg_wdata,
    output logic [DATA_W-1:0] eimr,
    output logic [DATA_W-1:0] palr,
    output logic [DATA_W-1:0] paur,
    output logic [DATA_W-1:0] tipg,
    output logic [DATA_W-1:0] tafl,
    output logic [DATA_W-1:0] taem,
    output logic [DATA_W-1:0] rafl,
    output logic [DATA_W-1:0] raem
);

    logic [DATA_W-1:0]    eimr_q;
    logic [DATA_W-1:0]    palr_q;
    logic [PAUR_HI_W-1:0] paur_hi;
    logic [TIPG_W-1:0]    tipg_q;
    logic [THR_W-1:0]     tafl_q;
    logic [THR_W-1:0]     taem_q;
    logic [THR_W-1:0]     rafl_q;
    logic [THR_W-1:0]     raem_q;

    logic [THR_W-1:0] thr_wr;
    logic [THR_W-1:0] tafl_wr;
    logic [THR_W-1:0] rafl_wr;
    logic [THR_W-1:0] aem_wr;

    assign thr_wr = reg_wdata[THR_W-1:0];

    // almost-full limits saturate high, almost-empty limits low
    assign tafl_wr = (thr_wr > THR_W'(TAFL_MAX)) ? THR_W'(TAFL_MAX) : thr_wr;
    assign rafl_wr = (thr_wr > THR_W'(RAFL_MAX)) ? THR_W'(RAFL_MAX) : thr_wr;
    assign aem_wr  = (thr_wr < THR_W'(AEM_MIN)) ? THR_W'(AEM_MIN) : thr_wr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            eimr_q  <= '0;
            palr_q  <= '0;
            paur_hi <= '0;
            tipg_q  <= TIPG_W'(TIPG_RST);
            tafl_q  <= THR_W'(TAFL_MAX);
            taem_q  <= THR_W'(AEM_MIN);
            rafl_q  <= THR_W'(RAFL_MAX);
            raem_q  <= THR_W'(AEM_MIN);
        end else if (cfg_we) begin
            case (cfg_id)
                REG_EIMR: eimr_q  <= reg_wdata;
                REG_PALR: palr_q  <= reg_wdata;
                REG_PAUR: paur_hi <= reg_wdata[DATA_W-1 -: PAUR_HI_W];
                REG_TIPG: tipg_q  <= reg_wdata[TIPG_W-1:0];
                REG_TAFL: tafl_q  <= tafl_wr;
                REG_TAEM: taem_q  <= aem_wr;
                REG_RAFL: rafl_q  <= rafl_wr;
                REG_RAEM: raem_q  <= aem_wr;
                default: ;
            endcase
        end
    end

    assign eimr = eimr_q;
    assign palr = palr_q;
    // low half is the fixed pause type field
    assign paur = {paur_hi, PAUR_TYPE};
    assign tipg = DATA_W'(tipg_q);
    assign tafl = DATA_W'(tafl_q);
    assign taem = DATA_W'(taem_q);
    assign rafl = DATA_W'(rafl_q);
    assign raem = DATA_W'(raem_q);

endmodule

// File: enet_status_regs.sv
`timescale 1ns/1ps

module enet_status_regs import enet_reg_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               reg_ren,
    input  logic [ADDR_W-1:0]  reg_addr,
    input  logic [DATA_W-1:0]  reg_wdata,
    input  logic               eir_clr_we,
    input  logic               tx_in_empty,
    input  logic               rx_in_empty,
    input  logic [REPLY_W-1:0] tx_in_data,
    input  logic [REPLY_W-1:0] rx_in_data,
    output logic [DATA_W-1:0]  tcr,
    output logic [DATA_W-1:0]  rcr,
    output logic [DATA_W-1:0]  tdar,
    output logic [DATA_W-1:0]  rdar,
    output logic               babr,
    output logic               babt,
    output logic               gra,
    output logic               eberr,
    output logic               lc,
    output logic               rl,
    output logic               un,
    output logic               plr,
    output logic               rxf,
    output logic               txf,
    output logic               read_done
);

    logic tx_ev, rx_ev;
    logic tcr_hit, tdar_hit, rcr_hit, rdar_hit;
    logic tdar_act, rdar_act;
    logic [7:0] flags;
    logic [7:0] flag_set;
    logic [7:0] flag_clr;

    // reply word present and addressed
    assign tx_ev    = !tx_in_empty && (tx_in_data[ADDR_W-1:0] == ADDR_EIR);
    assign rx_ev    = !rx_in_empty && (rx_in_data[ADDR_W-1:0] == ADDR_EIR);
    assign tcr_hit  = !tx_in_empty && (tx_in_data[ADDR_W-1:0] == ADDR_TCR);
    assign tdar_hit = !tx_in_empty && (tx_in_data[ADDR_W-1:0] == ADDR_TDAR);
    assign rcr_hit  = !rx_in_empty && (rx_in_data[ADDR_W-1:0] == ADDR_RCR);
    assign rdar_hit = !rx_in_empty && (rx_in_data[ADDR_W-1:0] == ADDR_RDAR);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tcr      <= '0;
            rcr      <= '0;
            tdar_act <= 1'b0;
            rdar_act <= 1'b0;
        end else begin
            if (tcr_hit) tcr <= tx_in_data[REPLY_W-1:ADDR_W];
            if (rcr_hit) rcr <= rx_in_data[REPLY_W-1:ADDR_W];
            if (tdar_hit) tdar_act <= tx_in_data[ADDR_W + DAR_ACTIVE_BIT];
            if (rdar_hit) rdar_act <= rx_in_data[ADDR_W + DAR_ACTIVE_BIT];
        end
    end

    assign tdar = DATA_W'(tdar_act) << DAR_ACTIVE_BIT;
    assign rdar = DATA_W'(rdar_act) << DAR_ACTIVE_BIT;

    // order: plr un rl lc eberr gra babt babr
    assign flag_set = {
        rx_ev && rx_in_data[EV_PLR],
        tx_ev && tx_in_data[EV_UN],
        tx_ev && tx_in_data[EV_RL],
        tx_ev && tx_in_data[EV_LC],
        (tx_ev && tx_in_data[EV_EBERR]) || (rx_ev && rx_in_data[EV_EBERR]),
        tx_ev && tx_in_data[EV_GRA],
        tx_ev && tx_in_data[EV_BABT],
        rx_ev && rx_in_data[EV_BABR]
    };

    assign flag_clr = {8{eir_clr_we}} & {reg_wdata[EIR_PLR], reg_wdata[EIR_UN],
                                         reg_wdata[EIR_RL], reg_wdata[EIR_LC],
                                         reg_wdata[EIR_EBERR], reg_wdata[EIR_GRA],
                                         reg_wdata[EIR_BABT], reg_wdata[EIR_BABR]};

    // a new event beats a clear in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else begin
            flags <= flag_set | (flags & ~flag_clr);
        end
    end

    assign {plr, un, rl, lc, eberr, gra, babt, babr} = flags;

    assign rxf = rx_ev && rx_in_data[EV_RXF];
    assign txf = tx_ev && tx_in_data[EV_TXF];

    assign read_done = reg_ren && ((tcr_hit  && reg_addr == ADDR_TCR)  ||
                                   (tdar_hit && reg_addr == ADDR_TDAR) ||
                                   (rcr_hit  && reg_addr == ADDR_RCR)  ||
                                   (rdar_hit && reg_addr == ADDR_RDAR));

endmodule

// File: enet_reg_top.sv
`timescale 1ns/1ps

module enet_reg_top import enet_reg_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               reg_wen,
    input  logic               reg_ren,
    input  logic [ADDR_W-1:0]  reg_addr,
    input  logic [DATA_W-1:0]  reg_wdata,
    output logic               write_success,
    output logic               read_done,
    input  logic               tx_out_full,
    output logic               tx_out_wen,
    output logic [MSG_W-1:0]   tx_out_data,
    input  logic               tx_in_empty,
    output logic               tx_in_ren,
    input  logic [REPLY_W-1:0] tx_in_data,
    input  logic               rx_out_full,
    output logic               rx_out_wen,
    output logic [MSG_W-1:0]   rx_out_data,
    input  logic               rx_in_empty,
    output logic               rx_in_ren,
    input  logic [REPLY_W-1:0] rx_in_data,
    output logic [DATA_W-1:0]  eimr,
    output logic [DATA_W-1:0]  palr,
    output logic [DATA_W-1:0]  paur,
    output logic [DATA_W-1:0]  tipg,
    output logic [DATA_W-1:0]  tafl,
    output logic [DATA_W-1:0]  taem,
    output logic [DATA_W-1:0]  rafl,
    output logic [DATA_W-1:0]  raem,
    output logic [DATA_W-1:0]  tcr,
    output logic [DATA_W-1:0]  rcr,
    output logic [DATA_W-1:0]  tdar,
    output logic [DATA_W-1:0]  rdar,
    output logic               babr,
    output logic               babt,
    output logic               gra,
    output logic               eberr,
    output logic               lc,
    output logic               rl,
    output logic               un,
    output logic               plr,
    output logic               rxf,
    output logic               txf
);

    logic    tx_send, rx_send;
    logic    tx_rd_req, rx_rd_req;
    logic    cfg_we, eir_clr_we;
    reg_id_e cfg_id;

    // reply fifos are drained every cycle
    assign tx_in_ren = 1'b1;
    assign rx_in_ren = 1'b1;

    enet_reg_decode u_decode (
        .reg_wen(reg_wen), .reg_ren(reg_ren), .reg_addr(reg_addr),
        .tx_out_full(tx_out_full), .rx_out_full(rx_out_full),
        .write_success(write_success), .tx_send(tx_send), .rx_send(rx_send),
        .tx_rd_req(tx_rd_req), .rx_rd_req(rx_rd_req),
        .cfg_we(cfg_we), .cfg_id(cfg_id), .eir_clr_we(eir_clr_we)
    );

    enet_msg_sender #(.CHAN(CHAN_TX)) u_tx_sender (
        .clk(clk), .rst_n(rst_n), .send(tx_send), .rd_req(tx_rd_req),
        .read_done(read_done), .out_full(tx_out_full),
        .reg_addr(reg_addr), .reg_wdata(reg_wdata),
        .out_wen(tx_out_wen), .out_data(tx_out_data)
    );

    enet_msg_sender #(.CHAN(CHAN_RX)) u_rx_sender (
        .clk(clk), .rst_n(rst_n), .send(rx_send), .rd_req(rx_rd_req),
        .read_done(read_done), .out_full(rx_out_full),
        .reg_addr(reg_addr), .reg_wdata(reg_wdata),
        .out_wen(rx_out_wen), .out_data(rx_out_data)
    );

    enet_cfg_regs u_cfg (
        .clk(clk), .rst_n(rst_n), .cfg_we(cfg_we), .cfg_id(cfg_id), .reg_wdata(reg_wdata),
        .eimr(eimr), .palr(palr), .paur(paur), .tipg(tipg),
        .tafl(tafl), .taem(taem), .rafl(rafl), .raem(raem)
    );

    enet_status_regs u_status (
        .clk(clk), .rst_n(rst_n), .reg_ren(reg_ren), .reg_addr(reg_addr),
        .reg_wdata(reg_wdata), .eir_clr_we(eir_clr_we),
        .tx_in_empty(tx_in_empty), .rx_in_empty(rx_in_empty),
        .tx_in_data(tx_in_data), .rx_in_data(rx_in_data),
        .tcr(tcr), .rcr(rcr), .tdar(tdar), .rdar(rdar),
        .babr(babr), .babt(babt), .gra(gra), .eberr(eberr), .lc(lc), .rl(rl),
        .un(un), .plr(plr), .rxf(rxf), .txf(txf), .read_done(read_done)
    );

endmodule

// File: tb_enet_reg_tasks.svh
// bit positions inside the expected flag vector
localparam int F_BABR  = 0;
localparam int F_BABT  = 1;
localparam int F_GRA   = 2;
localparam int F_EBERR = 3;
localparam int F_LC    = 4;
localparam int F_RL    = 5;
localparam int F_UN    = 6;
localparam int F_PLR   = 7;

logic [7:0] exp_flags;

task automatic next_cycle();
    @(posedge clk);
    #1;
endtask

function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
        // taps 32 22 2 1
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        v = {v[30:0], fb};
    end
    return v;
endfunction

task automatic check_val(input string test, input string what,
                         input logic [63:0] exp_v, input logic [63:0] act_v);
    assert (act_v === exp_v) else begin
        $display("mismatch %s %s: expected 0x%0h, actual 0x%0h", test, what, exp_v, act_v);
        stop_run();
    end
endtask

function automatic logic [7:0] flag_vec();
    logic [7:0] v;
    v[F_BABR]  = babr;
    v[F_BABT]  = babt;
    v[F_GRA]   = gra;
    v[F_EBERR] = eberr;
    v[F_LC]    = lc;
    v[F_RL]    = rl;
    v[F_UN]    = un;
    v[F_PLR]   = plr;
    return v;
endfunction

function automatic bit goes_to_tx(input logic [ADDR_W-1:0] addr);
    return addr inside {ADDR_PALR, ADDR_PAUR, ADDR_ECR, ADDR_TIPG, ADDR_TAFL, ADDR_TAEM};
endfunction

function automatic bit goes_to_rx(input logic [ADDR_W-1:0] addr);
    return addr inside {ADDR_PALR, ADDR_PAUR, ADDR_ECR, ADDR_RAFL, ADDR_RAEM};
endfunction

// value a local register should hold after accepting d
function automatic logic [31:0] cfg_expect(input logic [ADDR_W-1:0] addr,
                                           input logic [31:0] d);
    logic [7:0] t;
    t = d[7:0];
    case (addr)
        ADDR_PAUR: return {d[31:16], PAUR_TYPE};
        ADDR_TIPG: return {27'd0, d[4:0]};
        ADDR_TAFL: return (int'(t) > TAFL_MAX) ? 32'(TAFL_MAX) : {24'd0, t};
        ADDR_RAFL: return (int'(t) > RAFL_MAX) ? 32'(RAFL_MAX) : {24'd0, t};
        ADDR_TAEM, ADDR_RAEM: return (int'(t) < AEM_MIN) ? 32'(AEM_MIN) : {24'd0, t};
        default: return d;
    endcase
endfunction

function automatic logic [31:0] cfg_value(input logic [ADDR_W-1:0] addr);
    case (addr)
        ADDR_EIMR: return eimr;
        ADDR_PALR: return palr;
        ADDR_PAUR: return paur;
        ADDR_TIPG: return tipg;
        ADDR_TAFL: return tafl;
        ADDR_TAEM: return taem;
        ADDR_RAFL: return rafl;
        ADDR_RAEM: return raem;
        ADDR_TCR:  return tcr;
        ADDR_RCR:  return rcr;
        ADDR_TDAR: return tdar;
        default:   return rdar;
    endcase
endfunction

task automatic do_write(input string name, input logic [ADDR_W-1:0] addr,
                        input logic [31:0] d, input bit exp_ok, input bit exp_tx,
                        input bit exp_rx);
    logic [MSG_W-1:0] msg;
    msg = {d, addr, 1'b0};
    tx_seen.delete();
    rx_seen.delete();
    reg_wen   = 1'b1;
    reg_addr  = addr;
    reg_wdata = d;
    #1;
    check_val(name, "write_success", 64'(exp_ok), 64'(write_success));
    next_cycle();
    reg_wen = 1'b0;
    check_val(name, "tx_out_wen after strobe", 64'(exp_tx), 64'(tx_out_wen));
    check_val(name, "rx_out_wen after strobe", 64'(exp_rx), 64'(rx_out_wen));
    next_cycle();
    check_val(name, "tx_out_wen one cycle", 64'd0, 64'(tx_out_wen));
    check_val(name, "rx_out_wen one cycle", 64'd0, 64'(rx_out_wen));
    check_val(name, "tx messages", 64'(exp_tx), 64'(tx_seen.size()));
    check_val(name, "rx messages", 64'(exp_rx), 64'(rx_seen.size()));
    if (exp_tx) begin
        check_val(name, "tx message", 64'(msg), 64'(tx_seen[0]));
    end
    if (exp_rx) begin
        check_val(name, "rx message", 64'(msg), 64'(rx_seen[0]));
    end
endtask

task automatic write_and_check(input string name, input logic [ADDR_W-1:0] addr,
                               input logic [31:0] d);
    do_write(name, addr, d, 1'b1, goes_to_tx(addr), goes_to_rx(addr));
    check_val(name, "register value", 64'(cfg_expect(addr, d)), 64'(cfg_value(addr)));
endtask

task automatic check_reset_values();
    exp_flags = '0;
    check_val("reset", "tipg", 64'(TIPG_RST), 64'(tipg));
    check_val("reset", "tafl", 64'(TAFL_MAX), 64'(tafl));
    check_val("reset", "rafl", 64'(RAFL_MAX), 64'(rafl));
    check_val("reset", "taem", 64'(AEM_MIN), 64'(taem));
    check_val("reset", "raem", 64'(AEM_MIN), 64'(raem));
    check_val("reset", "paur", 64'(PAUR_TYPE), 64'(paur));
    check_val("reset", "eimr palr", 64'd0, {eimr, palr});
    check_val("reset", "tcr rcr", 64'd0, {tcr, rcr});
    check_val("reset", "tdar rdar", 64'd0, {tdar, rdar});
    check_val("reset", "flags", 64'd0, 64'(flag_vec()));
    check_val("reset", "rxf txf", 64'd0, 64'({rxf, txf}));
    check_val("reset", "write_success read_done", 64'd0, 64'({write_success, read_done}));
    check_val("reset", "in_ren", 64'd3, 64'({tx_in_ren, rx_in_ren}));
    check_val("reset", "tx_out_data", 64'd0, 64'(tx_out_data));
    check_val("reset", "rx_out_data", 64'd0, 64'(rx_out_data));
    for (int i = 0; i < 4; i++) begin
        check_val("reset", "out_wen", 64'd0, 64'({tx_out_wen, rx_out_wen}));
        next_cycle();
    end
    check_val("reset", "messages", 64'd0, 64'(tx_seen.size() + rx_seen.size()));
endtask

task automatic write_forwarding();
    logic [ADDR_W-1:0] addrs [7];
    addrs = '{ADDR_PALR, ADDR_PAUR, ADDR_TIPG, ADDR_TAFL, ADDR_TAEM, ADDR_RAFL, ADDR_RAEM};
    for (int i = 0; i < 7; i++) begin
        for (int k = 0; k < 2; k++) begin
            write_and_check("write_forward", addrs[i], rand_bits(32));
        end
    end
    // clamp corners
    write_and_check("write_forward", ADDR_TAFL, 32'h0000_00ff);
    write_and_check("write_forward", ADDR_RAFL, 32'h0000_00ff);
    write_and_check("write_forward", ADDR_TAEM, 32'h0000_0001);
    write_and_check("write_forward", ADDR_RAEM, 32'h0000_0000);
    write_and_check("write_forward", ADDR_TIPG, 32'hffff_ffff);
    do_write("write_forward ecr", ADDR_ECR, rand_bits(32), 1'b1, 1'b1, 1'b1);
endtask

task automatic backpressure_writes();
    logic [31:0] d;
    logic [31:0] old;
    tx_out_full = 1'b1;
    old = tipg;
    d = rand_bits(32);
    d[4:0] = ~old[4:0];
    do_write("backpressure tipg", ADDR_TIPG, d, 1'b0, 1'b0, 1'b0);
    check_val("backpressure tipg", "register kept", 64'(old), 64'(tipg));
    do_write("backpressure ecr", ADDR_ECR, rand_bits(32), 1'b0, 1'b0, 1'b0);
    d = rand_bits(32);
    do_write("backpressure rafl", ADDR_RAFL, d, 1'b1, 1'b0, 1'b1);
    check_val("backpressure rafl", "register value", 64'(cfg_expect(ADDR_RAFL, d)), 64'(rafl));
    d = rand_bits(32);
    do_write("backpressure eimr", ADDR_EIMR, d, 1'b1, 1'b0, 1'b0);
    check_val("backpressure eimr", "register value", 64'(d), 64'(eimr));
    tx_out_full = 1'b0;
endtask

task automatic remote_read(input string name, input logic [ADDR_W-1:0] addr, input bit on_tx,
                           input logic [31:0] reply, input logic [31:0] exp_reg);
    logic [31:0]      wd;
    logic [MSG_W-1:0] req;
    wd = rand_bits(32);
    req = {wd, addr, 1'b1};
    tx_seen.delete();
    rx_seen.delete();
    tx_out_full = on_tx;
    rx_out_full = !on_tx;
    reg_ren   = 1'b1;
    reg_addr  = addr;
    reg_wdata = wd;
    next_cycle();
    for (int i = 0; i < 6; i++) begin
        #1;
        check_val(name, "held request wen", 64'd1, 64'(on_tx ? tx_out_wen : rx_out_wen));
        check_val(name, "held request data", 64'(req),
                  64'(on_tx ? tx_out_data : rx_out_data));
        check_val(name, "other side wen", 64'd0, 64'(on_tx ? rx_out_wen : tx_out_wen));
        check_val(name, "read_done while blocked", 64'd0, 64'(read_done));
        next_cycle();
    end
    tx_out_full = 1'b0;
    rx_out_full = 1'b0;
    next_cycle();
    for (int i = 0; i < 4; i++) begin
        #1;
        check_val(name, "wen after accept", 64'd0, 64'({tx_out_wen, rx_out_wen}));
        check_val(name, "read_done before reply", 64'd0, 64'(read_done));
        next_cycle();
    end
    check_val(name, "tx requests", 64'(on_tx), 64'(tx_seen.size()));
    check_val(name, "rx requests", 64'(!on_tx), 64'(rx_seen.size()));
    if (on_tx) begin
        check_val(name, "accepted request", 64'(req), 64'(tx_seen[0]));
        tx_in_empty = 1'b0;
        tx_in_data  = {reply, addr};
    end else begin
        check_val(name, "accepted request", 64'(req), 64'(rx_seen[0]));
        rx_in_empty = 1'b0;
        rx_in_data  = {reply, addr};
    end
    #1;
    check_val(name, "read_done with reply", 64'd1, 64'(read_done));
    next_cycle();
    tx_in_empty = 1'b1;
    rx_in_empty = 1'b1;
    reg_ren     = 1'b0;
    #1;
    check_val(name, "mirror", 64'(exp_reg), 64'(cfg_value(addr)));
    check_val(name, "read_done after reply", 64'd0, 64'(read_done));
    next_cycle();
endtask

task automatic remote_reads();
    logic [31:0] d;
    d = rand_bits(32);
    remote_read("remote_read tcr", ADDR_TCR, 1'b1, d, d);
    d = rand_bits(32) | (32'd1 << DAR_ACTIVE_BIT);
    remote_read("remote_read rdar", ADDR_RDAR, 1'b0, d, 32'd1 << DAR_ACTIVE_BIT);
endtask

// one cycle of reply events, optionally with a host eir clear
task automatic drive_events(input string name, input bit tx_v, input logic [31:0] tx_d,
                            input bit rx_v, input logic [31:0] rx_d, input bit clr,
                            input logic [31:0] mask);
    logic [REPLY_W-1:0] tw;
    logic [REPLY_W-1:0] rw;
    logic [7:0]         set_v;
    logic [7:0]         clr_v;
    tw = {tx_d, ADDR_EIR};
    rw = {rx_d, ADDR_EIR};
    set_v = '0;
    if (tx_v) begin
        set_v[F_BABT]  = tw[EV_BABT];
        set_v[F_GRA]   = tw[EV_GRA];
        set_v[F_EBERR] = tw[EV_EBERR];
        set_v[F_LC]    = tw[EV_LC];
        set_v[F_RL]    = tw[EV_RL];
        set_v[F_UN]    = tw[EV_UN];
    end
    if (rx_v) begin
        set_v[F_BABR]  = rw[EV_BABR];
        set_v[F_EBERR] = set_v[F_EBERR] | rw[EV_EBERR];
        set_v[F_PLR]   = rw[EV_PLR];
    end
    clr_v = {mask[EIR_PLR], mask[EIR_UN], mask[EIR_RL], mask[EIR_LC],
             mask[EIR_EBERR], mask[EIR_GRA], mask[EIR_BABT], mask[EIR_BABR]};
    if (!clr) begin
        clr_v = '0;
    end
    tx_in_empty = !tx_v;
    tx_in_data  = tw;
    rx_in_empty = !rx_v;
    rx_in_data  = rw;
    reg_wen     = clr;
    reg_addr    = ADDR_EIR;
    reg_wdata   = mask;
    #1;
    check_val(name, "write_success", 64'(clr), 64'(write_success));
    check_val(name, "txf pulse", 64'(tx_v && tw[EV_TXF]), 64'(txf));
    check_val(name, "rxf pulse", 64'(rx_v && rw[EV_RXF]), 64'(rxf));
    next_cycle();
    tx_in_empty = 1'b1;
    rx_in_empty = 1'b1;
    reg_wen     = 1'b0;
    exp_flags = set_v | (exp_flags & ~clr_v);
    #1;
    check_val(name, "flags", 64'(exp_flags), 64'(flag_vec()));
    check_val(name, "rxf txf after word", 64'd0, 64'({rxf, txf}));
    next_cycle();
endtask

task automatic eir_flag_events();
    drive_events("eir_flags tx event", 1'b1, rand_bits(32), 1'b0, '0, 1'b0, '0);
    drive_events("eir_flags rx event", 1'b0, '0, 1'b1, rand_bits(32), 1'b0, '0);
    drive_events("eir_flags both", 1'b1, 32'hffff_ffff, 1'b1, 32'hffff_ffff, 1'b0, '0);
    drive_events("eir_flags clear mask", 1'b0, '0, 1'b0, '0, 1'b1, rand_bits(32));
    drive_events("eir_flags clear all", 1'b0, '0, 1'b0, '0, 1'b1, 32'hffff_ffff);
    // tx side alone must leave the rx-only flags low
    drive_events("eir_flags tx only", 1'b1, 32'hffff_ffff, 1'b0, '0, 1'b0, '0);
    drive_events("eir_flags set wins", 1'b1, 32'hffff_ffff, 1'b1, 32'hffff_ffff,
                 1'b1, 32'hffff_ffff);
endtask

// File: tb_enet_reg.sv
`timescale 1ns/1ps

module tb_enet_reg import enet_reg_pkg::*; ();

    // about 100 cycles of tests, with a wide margin
    localparam int TEST_CYCLES     = 100;
    localparam int WATCHDOG_CYCLES = 20 * TEST_CYCLES;

    logic               clk;
    logic               rst_n;
    logic               reg_wen;
    logic               reg_ren;
    logic [ADDR_W-1:0]  reg_addr;
    logic [DATA_W-1:0]  reg_wdata;
    logic               write_success;
    logic               read_done;
    logic               tx_out_full, rx_out_full;
    logic               tx_out_wen, rx_out_wen;
    logic [MSG_W-1:0]   tx_out_data, rx_out_data;
    logic               tx_in_empty, rx_in_empty;
    logic               tx_in_ren, rx_in_ren;
    logic [REPLY_W-1:0] tx_in_data, rx_in_data;
    logic [DATA_W-1:0]  eimr, palr, paur, tipg, tafl, taem, rafl, raem;
    logic [DATA_W-1:0]  tcr, rcr, tdar, rdar;
    logic               babr, babt, gra, eberr, lc, rl, un, plr, rxf, txf;

    // messages taken by the command fifo models
    logic [MSG_W-1:0] tx_seen [$];
    logic [MSG_W-1:0] rx_seen [$];

    logic [31:0] lfsr_state = 32'h6b8f_8288;

    enet_reg_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // fifo models take a word when wen is high and full is low
    always @(negedge clk) begin
        if (tx_out_wen && !tx_out_full) begin
            tx_seen.push_back(tx_out_data);
        end
        if (rx_out_wen && !rx_out_full) begin
            rx_seen.push_back(rx_out_data);
        end
    end

    task automatic stop_run();
        $display("Something failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    `include "tb_enet_reg_tasks.svh"

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the test sequence hung", WATCHDOG_CYCLES);
        stop_run();
    end

    initial begin
        rst_n       = 1'b0;
        reg_wen     = 1'b0;
        reg_ren     = 1'b0;
        reg_addr    = '0;
        reg_wdata   = '0;
        tx_out_full = 1'b0;
        rx_out_full = 1'b0;
        tx_in_empty = 1'b1;
        rx_in_empty = 1'b1;
        tx_in_data  = '0;
        rx_in_data  = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_reset_values();
        write_forwarding();
        backpressure_writes();
        remote_reads();
        eir_flag_events();
        $display("Everything OK");
        $finish;
    end

endmodule

// File: all.f
+incdir+.
enet_reg_pkg.sv
enet_reg_decode.sv
enet_msg_sender.sv
enet_cfg_regs.sv
enet_status_regs.sv
enet_reg_top.sv
tb_enet_reg.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_enet_reg -f all.f -o tb_enet_reg
./obj_dir/tb_enet_reg
